/* rtl/exec_pkg.sv */
package exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and constants
    ////////////////////////////////////////////////////////////////////////////

    // one multiply step per multiplier bit
    localparam int MUL_STEPS = 32;

    // data word
    typedef logic [31:0] word_t;

    // register index
    typedef logic [4:0] reg_addr_t;

    // step counter wide enough to hold MUL_STEPS
    typedef logic [$clog2(MUL_STEPS + 1) - 1:0] step_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // code 7 unused
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_EXEC,
        ST_WRITE
    } ctrl_state_t;

    // three-register instruction, 18 bits
    typedef struct packed {
        alu_op_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } instr_t;

    // write-back, 37 bits
    typedef struct packed {
        reg_addr_t rd;
        word_t     data;
    } result_t;

endpackage

/* rtl/instr_queue.sv */
`timescale 1ns/100ps

module instr_queue
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_push,
    input  exec_pkg::instr_t  i_push_instr,
    input  logic              i_pop,
    output exec_pkg::instr_t  o_head,
    output logic              o_not_empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // storage
    exec_pkg::instr_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // depth need not be a power of two so wrap by compare
            if (i_push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (i_push && !i_pop)
            begin
                count <= count + 1'b1;
            end
            else if (i_pop && !i_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // entry write
    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            mem[wr_ptr] <= i_push_instr;
        end
    end

    // head seen by the controller
    assign o_head      = mem[rd_ptr];
    assign o_not_empty = (count != '0);

    // producer must hold a credit to send
    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
        i_push |-> (count < QUEUE_DEPTH));

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> o_not_empty);

endmodule

/* rtl/step_timer.sv */
`timescale 1ns/100ps

module step_timer
(
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_start,
    output logic o_running,
    output logic o_last
);

    // remaining steps, zero when idle
    exec_pkg::step_cnt_t count;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            count <= '0;
        end
        else if (i_start)
        begin
            count <= exec_pkg::step_cnt_t'(exec_pkg::MUL_STEPS);
        end
        else if (o_running)
        begin
            count <= count - 1'b1;
        end
    end

    assign o_running = (count != '0);
    // final counting cycle
    assign o_last    = (count == exec_pkg::step_cnt_t'(1));

    // a new multiply only once the previous one has drained
    a_no_restart: assert property (@(posedge i_clk) disable iff (i_reset)
        i_start |-> !o_running);

endmodule

/* rtl/exec_control.sv */
`timescale 1ns/100ps

module exec_control
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_not_empty,
    input  exec_pkg::instr_t    i_head,
    input  logic                i_timer_last,
    output logic                o_pop,
    output logic                o_timer_start,
    output exec_pkg::reg_addr_t o_rs_addr,
    output exec_pkg::reg_addr_t o_rt_addr,
    output exec_pkg::alu_op_t   o_op,
    output logic                o_alu_start,
    output logic                o_alu_step,
    output logic                o_wr_en,
    output exec_pkg::result_t   o_wr,
    input  exec_pkg::word_t     i_alu_result
);

    exec_pkg::ctrl_state_t state;
    // instruction in flight
    exec_pkg::instr_t      instr;
    logic                  is_mul;

    assign is_mul = (instr.op == exec_pkg::OP_MUL);

    ////////////////////////////////////////////////////////////////////////////
    // sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state <= exec_pkg::ST_IDLE;
        end
        else
        begin
            case (state)
                exec_pkg::ST_IDLE:
                begin
                    if (i_not_empty)
                    begin
                        state <= exec_pkg::ST_READ;
                    end
                end
                exec_pkg::ST_READ:
                begin
                    state <= exec_pkg::ST_EXEC;
                end
                exec_pkg::ST_EXEC:
                begin
                    // single-cycle ops leave at once
                    if (!is_mul || i_timer_last)
                    begin
                        state <= exec_pkg::ST_WRITE;
                    end
                end
                default:
                begin
                    state <= exec_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // latch on pop
    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            instr <= i_head;
        end
    end

    // pop doubles as the returned credit
    assign o_pop         = (state == exec_pkg::ST_IDLE) && i_not_empty;

    // operand read and ALU kick-off
    assign o_rs_addr     = instr.rs;
    assign o_rt_addr     = instr.rt;
    assign o_op          = instr.op;
    assign o_alu_start   = (state == exec_pkg::ST_READ);
    assign o_timer_start = (state == exec_pkg::ST_READ) && is_mul;
    assign o_alu_step    = (state == exec_pkg::ST_EXEC) && is_mul;

    // write-back is also the result port
    assign o_wr_en       = (state == exec_pkg::ST_WRITE);
    assign o_wr.rd       = instr.rd;
    assign o_wr.data     = i_alu_result;

    // timer must end every multiply in time
    a_exec_bounded: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(state == exec_pkg::ST_EXEC)
        |-> ##[1:exec_pkg::MUL_STEPS] (state != exec_pkg::ST_EXEC));

endmodule

/* rtl/register_file.sv */
`timescale 1ns/100ps

module register_file
(
    input  logic                i_clk,
    input  logic                i_reset,
    input  exec_pkg::reg_addr_t i_rs_addr,
    input  exec_pkg::reg_addr_t i_rt_addr,
    input  logic                i_wr_en,
    input  exec_pkg::result_t   i_wr,
    output exec_pkg::word_t     o_rs_data,
    output exec_pkg::word_t     o_rt_data
);

    localparam int NUM_REGS = 2 ** $bits(exec_pkg::reg_addr_t);

    exec_pkg::word_t regs [NUM_REGS];

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            // every register comes up holding its index
            // register 0 included
            for (int idx = 0; idx < NUM_REGS; idx++)
            begin
                regs[idx] <= exec_pkg::word_t'(idx);
            end
        end
        else if (i_wr_en)
        begin
            regs[i_wr.rd] <= i_wr.data;
        end
    end

    // combinational read ports
    assign o_rs_data = regs[i_rs_addr];
    assign o_rt_data = regs[i_rt_addr];

endmodule

/* rtl/alu.sv */
`timescale 1ns/100ps

module alu
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_start,
    input  logic              i_step,
    input  exec_pkg::alu_op_t i_op,
    input  exec_pkg::word_t   i_a,
    input  exec_pkg::word_t   i_b,
    output exec_pkg::word_t   o_result
);

    // shifted multiplicand and remaining multiplier bits
    exec_pkg::word_t mcand;
    exec_pkg::word_t mplier;
    // result register, also the multiply accumulator
    exec_pkg::word_t acc;
    exec_pkg::word_t single_res;

    ////////////////////////////////////////////////////////////////////////////
    // single-cycle ops
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (i_op)
            exec_pkg::OP_ADD: single_res = i_a + i_b;
            exec_pkg::OP_SUB: single_res = i_a - i_b;
            exec_pkg::OP_AND: single_res = i_a & i_b;
            exec_pkg::OP_OR:  single_res = i_a | i_b;
            exec_pkg::OP_XOR: single_res = i_a ^ i_b;
            // signed compare
            exec_pkg::OP_SLT: single_res = ($signed(i_a) < $signed(i_b)) ? 32'd1 : 32'd0;
            default:          single_res = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // operand latch and shift-add multiply
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            acc <= '0;
        end
        else if (i_start)
        begin
            // multiply starts from an empty accumulator
            acc <= (i_op == exec_pkg::OP_MUL) ? '0 : single_res;
        end
        else if (i_step && mplier[0])
        begin
            acc <= acc + mcand;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            mcand  <= i_a;
            mplier <= i_b;
        end
        else if (i_step)
        begin
            // one multiplier bit per step
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign o_result = acc;

    // controller and timer together supply an unbroken run of steps
    a_mul_steps: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_start && i_op == exec_pkg::OP_MUL) |=> i_step [*exec_pkg::MUL_STEPS]);

endmodule

/* rtl/exec_unit_top.sv */
`timescale 1ns/100ps

module exec_unit_top
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_instr_valid,
    input  exec_pkg::instr_t  i_instr,
    output logic              o_credit,
    output logic              o_result_valid,
    output exec_pkg::result_t o_result
);

    ////////////////////////////////////////////////////////////////////////////
    // internal wiring
    ////////////////////////////////////////////////////////////////////////////

    // queue to controller
    exec_pkg::instr_t    head;
    logic                not_empty;
    logic                pop;

    // multiply pacing
    logic                timer_start;
    logic                timer_running;
    logic                timer_last;

    // register read and write-back
    exec_pkg::reg_addr_t rs_addr;
    exec_pkg::reg_addr_t rt_addr;
    exec_pkg::word_t     rs_data;
    exec_pkg::word_t     rt_data;
    logic                wr_en;
    exec_pkg::result_t   wr;

    // alu control
    exec_pkg::alu_op_t   op;
    logic                alu_start;
    logic                alu_step;
    logic                alu_step_gated;
    exec_pkg::word_t     alu_result;

    // steps only while the timer counts
    assign alu_step_gated = alu_step & timer_running;

    // credit and result port come straight from the controller
    assign o_credit       = pop;
    assign o_result_valid = wr_en;
    assign o_result       = wr;

    ////////////////////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////////////////////

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_push       (i_instr_valid),
        .i_push_instr (i_instr),
        .i_pop        (pop),
        .o_head       (head),
        .o_not_empty  (not_empty)
    );

    exec_control u_control (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_not_empty   (not_empty),
        .i_head        (head),
        .i_timer_last  (timer_last),
        .o_pop         (pop),
        .o_timer_start (timer_start),
        .o_rs_addr     (rs_addr),
        .o_rt_addr     (rt_addr),
        .o_op          (op),
        .o_alu_start   (alu_start),
        .o_alu_step    (alu_step),
        .o_wr_en       (wr_en),
        .o_wr          (wr),
        .i_alu_result  (alu_result)
    );

    step_timer u_timer (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_start   (timer_start),
        .o_running (timer_running),
        .o_last    (timer_last)
    );

    register_file u_regs (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .i_wr_en   (wr_en),
        .i_wr      (wr),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    alu u_alu (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_start  (alu_start),
        .i_step   (alu_step_gated),
        .i_op     (op),
        .i_a      (rs_data),
        .i_b      (rt_data),
        .o_result (alu_result)
    );

endmodule

/* verification/exec_checker.sv */
`timescale 1ns/100ps

module exec_checker
#(
    parameter int QUEUE_DEPTH = 4
)
(
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_instr_valid,
    input  exec_pkg::instr_t  i_instr,
    input  logic              i_credit,
    input  logic              i_result_valid,
    input  exec_pkg::result_t i_result,
    output int                o_results,
    output int                o_value_errors,
    output int                o_protocol_errors
);

    // sent but not yet written back in send order
    exec_pkg::instr_t sent_q [$];
    // cycle of the credit pulse for each popped instruction
    int               credit_cycle_q [$];
    exec_pkg::word_t  model_regs [32];
    int               cycle;
    int               credits_held;

    // expected write-back value from the op definitions
    function automatic exec_pkg::word_t expected_value(
        input exec_pkg::alu_op_t op,
        input exec_pkg::word_t   a,
        input exec_pkg::word_t   b
    );
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [63:0]        product;
        sa      = a;
        sb      = b;
        product = {32'd0, a} * {32'd0, b};
        case (op)
            exec_pkg::OP_ADD: return a + b;
            exec_pkg::OP_SUB: return a - b;
            exec_pkg::OP_AND: return a & b;
            exec_pkg::OP_OR:  return a | b;
            exec_pkg::OP_XOR: return a ^ b;
            exec_pkg::OP_SLT: return (sa < sb) ? 32'd1 : 32'd0;
            // low half of the product only
            exec_pkg::OP_MUL: return product[31:0];
            default:          return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // sampled mid-cycle once DUT signals have settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge i_clk)
    begin
        exec_pkg::instr_t  exp_instr;
        exec_pkg::alu_op_t exp_op;
        exec_pkg::word_t   exp_data;
        int                latency;
        int                exp_latency;
        if (i_reset)
        begin
            // register i holds i after reset
            for (int idx = 0; idx < 32; idx++)
            begin
                model_regs[idx] = exec_pkg::word_t'(idx);
            end
            sent_q.delete();
            credit_cycle_q.delete();
            cycle        = 0;
            credits_held = QUEUE_DEPTH;
        end
        else
        begin
            cycle++;
            // producer side of the credit link
            if (i_instr_valid)
            begin
                if (credits_held <= 0)
                begin
                    $display("credit violation at %0t: instruction sent with no credit held",
                             $time);
                    o_protocol_errors++;
                end
                credits_held--;
                sent_q.push_back(i_instr);
            end
            if (i_credit)
            begin
                credits_held++;
                if (credits_held > QUEUE_DEPTH)
                begin
                    $display("credit violation at %0t: credit returned that was never taken",
                             $time);
                    o_protocol_errors++;
                end
                credit_cycle_q.push_back(cycle);
            end
            // write-back in send order
            if (i_result_valid)
            begin
                if (sent_q.size() == 0 || credit_cycle_q.size() == 0)
                begin
                    $display("protocol failure at %0t: result with no instruction outstanding",
                             $time);
                    o_protocol_errors++;
                end
                else
                begin
                    exp_instr   = sent_q.pop_front();
                    exp_op      = exp_instr.op;
                    latency     = cycle - credit_cycle_q.pop_front();
                    exp_data    = expected_value(exp_op, model_regs[exp_instr.rs],
                                                 model_regs[exp_instr.rt]);
                    exp_latency = (exp_op == exec_pkg::OP_MUL) ?
                                  exec_pkg::MUL_STEPS + 2 : 3;
                    if (i_result.rd !== exp_instr.rd)
                    begin
                        $display("** Error at %0t: rd %0d, expected %0d",
                                 $time, i_result.rd, exp_instr.rd);
                        o_value_errors++;
                    end
                    if (i_result.data !== exp_data)
                    begin
                        $display("** Error at %0t: %s r%0d data 0x%08h, expected 0x%08h", $time,
                                 exp_op.name(), exp_instr.rd, i_result.data, exp_data);
                        o_value_errors++;
                    end
                    if (latency != exp_latency)
                    begin
                        $display({"** Error at %0t: %s result %0d cycles after credit,",
                                  " expected %0d"},
                                 $time, exp_op.name(), latency, exp_latency);
                        o_value_errors++;
                    end
                    // later instructions read the model's value
                    model_regs[exp_instr.rd] = exp_data;
                end
                o_results++;
            end
        end
    end

endmodule

/* verification/tb_exec_unit.sv */
`timescale 1ns/100ps

module tb_exec_unit;

    localparam int DEPTH       = 4;
    localparam int NUM_INSTR   = 300;
    localparam int STALL_LIMIT = 200;
    localparam int SEND_LIMIT  = 20000;
    localparam int DRAIN_LIMIT = 2000;
    localparam int QUIET       = 5;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    exec_pkg::instr_t  instr;
    logic              credit;
    logic              result_valid;
    exec_pkg::result_t result;

    int                results;
    int                value_errors;
    int                protocol_errors;
    int                stim_errors;
    int                credits;
    int                sent;
    logic              saw_zero;
    logic [31:0]       lfsr_state;

    always #5 clk = ~clk;

    exec_unit_top #(.QUEUE_DEPTH(DEPTH)) uut (
        .i_clk          (clk),
        .i_reset        (reset),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .o_credit       (credit),
        .o_result_valid (result_valid),
        .o_result       (result)
    );

    exec_checker #(.QUEUE_DEPTH(DEPTH)) u_checker (
        .i_clk             (clk),
        .i_reset           (reset),
        .i_instr_valid     (instr_valid),
        .i_instr           (instr),
        .i_credit          (credit),
        .i_result_valid    (result_valid),
        .i_result          (result),
        .o_results         (results),
        .o_value_errors    (value_errors),
        .o_protocol_errors (protocol_errors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////////////////////

    // right-shift Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // lsb first with one LFSR step per bit
    task automatic take_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int idx = 0; idx < width; idx++)
        begin
            lfsr_state = galois_step(lfsr_state);
            value[idx] = lfsr_state[0];
        end
    endtask

    // credit pulse of this cycle is usable from the next one
    task automatic advance_cycle();
        if (credit)
        begin
            credits++;
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] bits;
        int          stall;
        int          cycles;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr_state  = 32'd81186;
        stim_errors = 0;
        sent        = 0;
        saw_zero    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset   = 1'b0;
        credits = uut.QUEUE_DEPTH;
        // quiet window before the first instruction
        repeat (QUIET) advance_cycle();

        stall  = 0;
        cycles = 0;
        while (sent < NUM_INSTR && stall < STALL_LIMIT && cycles < SEND_LIMIT)
        begin
            instr_valid = 1'b0;
            if (credits == 0)
            begin
                // queue full behind a multiply
                saw_zero = 1'b1;
                stall++;
            end
            else
            begin
                stall = 0;
                take_bits(1, bits);
                if (bits[0])
                begin
                    take_bits(3, bits);
                    instr.op = (bits[2:0] == 3'd7) ? exec_pkg::OP_ADD
                                                   : exec_pkg::alu_op_t'(bits[2:0]);
                    take_bits(5, bits);
                    instr.rs = bits[4:0];
                    take_bits(5, bits);
                    instr.rt = bits[4:0];
                    take_bits(5, bits);
                    instr.rd = bits[4:0];
                    // first one reads reset values so r3 + r5 gives 8
                    if (sent == 0)
                    begin
                        instr.op = exec_pkg::OP_ADD;
                        instr.rs = 5'd3;
                        instr.rt = 5'd5;
                        instr.rd = 5'd8;
                    end
                    instr_valid = 1'b1;
                    credits--;
                    sent++;
                end
            end
            advance_cycle();
            cycles++;
        end
        instr_valid = 1'b0;
        if (stall >= STALL_LIMIT)
        begin
            $display("timeout: no credit came back for %0d cycles", STALL_LIMIT);
            stim_errors++;
        end
        else if (sent < NUM_INSTR)
        begin
            $display("timeout: only %0d of %0d instructions sent", sent, NUM_INSTR);
            stim_errors++;
        end

        // drain
        cycles = 0;
        while (results < sent && cycles < DRAIN_LIMIT)
        begin
            advance_cycle();
            cycles++;
        end
        if (results < sent)
        begin
            $display("timeout: only %0d of %0d results arrived", results, sent);
            stim_errors++;
        end
        repeat (QUIET) advance_cycle();
        if (results != sent)
        begin
            $display("result count %0d does not match %0d instructions sent", results, sent);
            stim_errors++;
        end
        if (credits != uut.QUEUE_DEPTH)
        begin
            $display("holding %0d credits after drain instead of %0d", credits, uut.QUEUE_DEPTH);
            stim_errors++;
        end
        if (!saw_zero)
        begin
            $display("credit counter never reached zero so back-pressure was not exercised");
            stim_errors++;
        end

        $display("errors: value %0d, protocol %0d, stimulus %0d",
                 value_errors, protocol_errors, stim_errors);
        if (value_errors + protocol_errors + stim_errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sim.f */
rtl/exec_pkg.sv
rtl/instr_queue.sv
rtl/step_timer.sv
rtl/exec_control.sv
rtl/register_file.sv
rtl/alu.sv
rtl/exec_unit_top.sv
verification/exec_checker.sv
verification/tb_exec_unit.sv
